/* common/game_pkg.sv */
package game_pkg;

	// Width of a guess and of the hidden number
	localparam int GUESS_W = 8;

	// Width of the remaining-guess counter
	localparam int COUNT_W = 3;

	// Guesses allowed per game
	localparam int MAX_GUESSES = 7;

	// Result of comparing the guess with the hidden number
	typedef struct packed {
		logic over;
		logic under;
		logic equal;
	} cmp_flags_t;

	// Active-low seven-segment pattern, bit 0 is segment a, bit 6 is g
	typedef logic [6:0] seg_t;

	// All segments dark
	localparam seg_t SEG_OFF = 7'h7f;

	// Game FSM states
	typedef enum logic [1:0] {
		ST_SEED,
		ST_GUESS,
		ST_CHECK,
		ST_DONE
	} ctrl_state_t;

endpackage

/* compile.f */
common/game_pkg.sv
design/key_sync.sv
datapath/datapath.sv
control/control.sv
design/led_ctrl.sv
design/hex_decoder.sv
design/guess_game_top.sv
verif/tb_guess_game.sv

/* control/control.sv */
`timescale 1ns/1ps

module control (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  logic                 i_enter,
	input  game_pkg::cmp_flags_t i_flags,
	input  logic                 i_game_over,
	output logic                 o_inc_actual,
	output logic                 o_dec_count,
	output logic                 o_new_game,
	output logic                 o_update_leds
);

	import game_pkg::*;

	ctrl_state_t state_q;
	ctrl_state_t state_d;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q <= ST_SEED;
		end else begin
			state_q <= state_d;
		end
	end

	// Next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_SEED: begin
				// First guess freezes the hidden number
				if (i_enter) begin
					state_d = ST_CHECK;
				end
			end
			ST_GUESS: begin
				if (i_enter) begin
					state_d = ST_CHECK;
				end
			end
			ST_CHECK: begin
				// Single cycle, decide the game here
				if (i_flags.equal || i_game_over) begin
					state_d = ST_DONE;
				end else begin
					state_d = ST_GUESS;
				end
			end
			ST_DONE: begin
				if (i_enter) begin
					state_d = ST_SEED;
				end
			end
			default: begin
				state_d = ST_SEED;
			end
		endcase
	end

	// Moore outputs from the state
	assign o_inc_actual  = (state_q == ST_SEED);
	assign o_dec_count   = (state_q == ST_CHECK);
	assign o_update_leds = (state_q == ST_CHECK);

	// Enter is already a single-cycle strobe
	assign o_new_game = (state_q == ST_DONE) && i_enter;

endmodule

/* datapath/datapath.sv */
`timescale 1ns/1ps

module datapath (
	input  logic                        clk,
	input  logic                        i_rst_n,
	input  logic [game_pkg::GUESS_W-1:0] i_guess,
	input  logic                        i_inc_actual,
	input  logic                        i_dec_count,
	input  logic                        i_new_game,
	output logic [game_pkg::COUNT_W-1:0] o_guess_count,
	output game_pkg::cmp_flags_t        o_flags,
	output logic                        o_game_over
);

	import game_pkg::*;

	logic [GUESS_W-1:0] actual_q;
	logic [COUNT_W-1:0] count_q;
	logic               last_guess;

	// Hidden number runs freely while seeding, wraps at the top
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			actual_q <= '0;
		end else if (i_inc_actual) begin
			actual_q <= actual_q + 1'b1;
		end
	end

	// Remaining guesses
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			count_q <= COUNT_W'(MAX_GUESSES);
		end else if (i_new_game) begin
			count_q <= COUNT_W'(MAX_GUESSES);
		end else if (i_dec_count && count_q != '0) begin
			count_q <= count_q - 1'b1;
		end
	end

	assign o_guess_count = count_q;

	// The decrement in flight uses up the final guess
	assign last_guess  = (count_q == COUNT_W'(1)) && i_dec_count;
	assign o_game_over = (count_q == '0) || last_guess;

	// Exactly one flag is set for any guess
	always_comb begin
		o_flags.over  = (i_guess > actual_q);
		o_flags.under = (i_guess < actual_q);
		o_flags.equal = (i_guess == actual_q);
	end

endmodule

/* design/guess_game_top.sv */
`timescale 1ns/1ps

module guess_game_top (
	input  logic           clk,
	input  logic           i_rst_n,
	input  logic [3:0]     i_key_n,
	input  logic [9:0]     i_sw,
	output game_pkg::seg_t o_hex0,
	output game_pkg::seg_t o_hex1,
	output game_pkg::seg_t o_hex2,
	output game_pkg::seg_t o_hex3,
	output game_pkg::seg_t o_hex4,
	output game_pkg::seg_t o_hex5,
	output logic [9:0]     o_ledr
);

	import game_pkg::*;

	logic               enter_stb;
	logic [GUESS_W-1:0] guess;
	logic               inc_actual;
	logic               dec_count;
	logic               new_game;
	logic               update_leds;
	logic [COUNT_W-1:0] guess_count;
	cmp_flags_t         flags;
	logic               game_over;

	assign guess = i_sw[GUESS_W-1:0];

	// KEY[1] is the enter key
	key_sync u_key_sync (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_key_n (i_key_n[1]),
		.o_press (enter_stb)
	);

	datapath u_datapath (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_guess       (guess),
		.i_inc_actual  (inc_actual),
		.i_dec_count   (dec_count),
		.i_new_game    (new_game),
		.o_guess_count (guess_count),
		.o_flags       (flags),
		.o_game_over   (game_over)
	);

	control u_control (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_enter       (enter_stb),
		.i_flags       (flags),
		.i_game_over   (game_over),
		.o_inc_actual  (inc_actual),
		.o_dec_count   (dec_count),
		.o_new_game    (new_game),
		.o_update_leds (update_leds)
	);

	led_ctrl u_led_ctrl (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_flags     (flags),
		.i_game_over (game_over),
		.i_update    (update_leds),
		.i_clear     (new_game),
		.o_ledr      (o_ledr)
	);

	// Guess in hex on the two rightmost digits
	hex_decoder u_hex_guess0 (
		.i_digit    (guess[3:0]),
		.o_segments (o_hex0)
	);

	hex_decoder u_hex_guess1 (
		.i_digit    (guess[7:4]),
		.o_segments (o_hex1)
	);

	hex_decoder u_hex_count (
		.i_digit    (4'(guess_count)),
		.o_segments (o_hex5)
	);

	// Unused digits stay dark
	assign o_hex2 = SEG_OFF;
	assign o_hex3 = SEG_OFF;
	assign o_hex4 = SEG_OFF;

endmodule

/* design/hex_decoder.sv */
`timescale 1ns/1ps

module hex_decoder (
	input  logic [3:0]     i_digit,
	output game_pkg::seg_t o_segments
);

	// Segments are lit by a zero
	always_comb begin
		case (i_digit)
			4'h0: o_segments = 7'h40;
			4'h1: o_segments = 7'h79;
			4'h2: o_segments = 7'h24;
			4'h3: o_segments = 7'h30;
			4'h4: o_segments = 7'h19;
			4'h5: o_segments = 7'h12;
			4'h6: o_segments = 7'h02;
			4'h7: o_segments = 7'h78;
			4'h8: o_segments = 7'h00;
			4'h9: o_segments = 7'h10;
			4'ha: o_segments = 7'h08;
			4'hb: o_segments = 7'h03;
			4'hc: o_segments = 7'h46;
			4'hd: o_segments = 7'h21;
			4'he: o_segments = 7'h06;
			default: o_segments = 7'h0e;
		endcase
	end

endmodule

/* design/key_sync.sv */
`timescale 1ns/1ps

module key_sync (
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_key_n,
	output logic o_press
);

	logic sync_q1;
	logic sync_q2;
	logic pressed_q;
	logic pressed;

	// Key is active low
	assign pressed = ~sync_q2;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sync_q1   <= 1'b1;
			sync_q2   <= 1'b1;
			pressed_q <= 1'b0;
			o_press   <= 1'b0;
		end else begin
			sync_q1   <= i_key_n;
			sync_q2   <= sync_q1;
			pressed_q <= pressed;
			// One pulse per released-to-pressed transition
			o_press   <= pressed & ~pressed_q;
		end
	end

endmodule

/* design/led_ctrl.sv */
`timescale 1ns/1ps

module led_ctrl (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  game_pkg::cmp_flags_t i_flags,
	input  logic                 i_game_over,
	input  logic                 i_update,
	input  logic                 i_clear,
	output logic [9:0]           o_ledr
);

	import game_pkg::*;

	cmp_flags_t flags_q;
	logic       lost_q;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			flags_q <= '0;
			lost_q  <= 1'b0;
		end else if (i_clear) begin
			flags_q <= '0;
			lost_q  <= 1'b0;
		end else if (i_update) begin
			flags_q <= i_flags;
			// Out of guesses without a hit
			lost_q  <= i_game_over & ~i_flags.equal;
		end
	end

	always_comb begin
		o_ledr    = '0;
		o_ledr[9] = flags_q.under;
		o_ledr[5] = lost_q;
		o_ledr[4] = flags_q.equal;
		o_ledr[0] = flags_q.over;
	end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --top-module tb_guess_game -f compile.f -o tb_sim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -qx "TEST OK" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

/* verif/tb_guess_game.sv */
`timescale 1ns/1ps

module tb_guess_game;

	import game_pkg::*;

	// Active-low glyphs indexed by digit, bit 0 is segment a
	localparam seg_t GLYPHS [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
	};

	logic       clk;
	logic       i_rst_n;
	logic [3:0] i_key_n;
	logic [9:0] i_sw;
	seg_t       o_hex0, o_hex1, o_hex2, o_hex3, o_hex4, o_hex5;
	logic [9:0] o_ledr;
	int         checks;
	int         errors;

	guess_game_top uut (.*);

	always #2 clk = ~clk;

	task automatic check_seg(input string name, input seg_t got, input seg_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_leds(input string name, input logic [9:0] got, input logic [9:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input logic [COUNT_W-1:0] got,
			input logic [COUNT_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Read the remaining count back from the HEX5 glyph
	task automatic check_hex5_count(input logic [COUNT_W-1:0] exp);
		logic [COUNT_W-1:0] shown;
		bit                 found;
		shown = '0;
		found = 1'b0;
		for (logic [3:0] d = 4'd0; d < 4'd8; d++) begin
			if (GLYPHS[d] == o_hex5) begin
				shown = d[COUNT_W-1:0];
				found = 1'b1;
			end
		end
		if (found) begin
			check_count("o_hex5", shown, exp);
		end else begin
			errors++;
			$display("HEX5 shows pattern %h, which is not a digit from 0 to 7", o_hex5);
		end
	endtask

	task automatic set_guess(input logic [9:0] value);
		@(negedge clk);
		i_sw = value;
	endtask

	// Count changes on the fifth edge after the key falls
	task automatic press_enter(input int low_cycles, input logic [COUNT_W-1:0] cnt_before,
			input logic [COUNT_W-1:0] cnt_after);
		@(negedge clk);
		i_key_n[1] = 1'b0;
		for (int c = 1; c <= low_cycles + 4; c++) begin
			@(negedge clk);
			if (c == low_cycles) begin
				i_key_n[1] = 1'b1;
			end
			if (c == 4) begin
				check_hex5_count(cnt_before);
			end
			if (c == 5 || c == low_cycles + 4) begin
				check_hex5_count(cnt_after);
			end
		end
	endtask

	task automatic wait_leds(input bit want_clear);
		bit done;
		done = 1'b0;
		for (int t = 0; t < 20 && !done; t++) begin
			if (want_clear) begin
				done = (o_ledr == '0);
			end else begin
				done = ($countones({o_ledr[9], o_ledr[4], o_ledr[0]}) == 1);
			end
			if (!done) begin
				@(negedge clk);
			end
		end
		if (!done) begin
			errors++;
			$display("LEDs did not reach the %s state within 20 cycles",
				want_clear ? "cleared" : "feedback");
		end
	endtask

	// One guess; lost LED only on the last guess without a hit
	task automatic take_guess(input logic [7:0] value, input logic [COUNT_W-1:0] left,
			output logic [9:0] exp);
		set_guess({2'b00, value});
		press_enter(4, left, left - 1'b1);
		wait_leds(1'b0);
		exp = '0;
		exp[9] = o_ledr[9];
		exp[4] = o_ledr[4];
		exp[0] = o_ledr[0];
		exp[5] = (left == COUNT_W'(1)) && !o_ledr[4];
		check_leds("o_ledr", o_ledr, exp);
	endtask

	// Game is over: switches change nothing, one press starts afresh
	task automatic end_game(input logic [COUNT_W-1:0] left, input logic [9:0] exp_leds);
		set_guess(10'($urandom));
		repeat (6) @(negedge clk);
		check_leds("o_ledr", o_ledr, exp_leds);
		check_hex5_count(left);
		press_enter(4, COUNT_W'(MAX_GUESSES), COUNT_W'(MAX_GUESSES));
		wait_leds(1'b1);
		check_leds("o_ledr", o_ledr, '0);
	endtask

	task automatic play_binary(output bit won);
		int                 lo;
		int                 hi;
		int                 g;
		logic [COUNT_W-1:0] left;
		logic [9:0]         leds;
		lo = 0;
		hi = 255;
		left = COUNT_W'(MAX_GUESSES);
		won = 1'b0;
		repeat ($urandom_range(200, 0)) @(negedge clk);
		while (!won && left != '0) begin
			g = (lo + hi) / 2;
			take_guess(8'(g), left, leds);
			left = left - 1'b1;
			won = leds[4];
			if (leds[9]) lo = g + 1;
			if (leds[0]) hi = g - 1;
			if (lo > hi) begin
				errors++;
				$display("Feedback leaves no possible hidden number");
			end
		end
		end_game(left, leds);
	endtask

	task automatic play_extremes();
		logic [COUNT_W-1:0] left;
		logic [9:0]         leds;
		bit                 high;
		bit                 won;
		left = COUNT_W'(MAX_GUESSES);
		high = 1'b0;
		won = 1'b0;
		while (!won && left != '0) begin
			take_guess(high ? 8'hff : 8'h00, left, leds);
			left = left - 1'b1;
			won = leds[4];
			// Under means zero was wrong, so go high next
			high = leds[9];
		end
		end_game(left, leds);
	endtask

	initial begin
		bit won;
		int games;
		void'($urandom(32'ha2fb));
		clk = 1'b0;
		i_rst_n = 1'b0;
		i_key_n = '1;
		i_sw = '0;
		checks = 0;
		errors = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		i_rst_n = 1'b1;

		check_leds("o_ledr", o_ledr, '0);
		check_hex5_count(COUNT_W'(MAX_GUESSES));
		check_seg("o_hex2", o_hex2, 7'h7f);
		check_seg("o_hex3", o_hex3, 7'h7f);
		check_seg("o_hex4", o_hex4, 7'h7f);

		repeat (16) begin
			set_guess(10'($urandom));
			@(posedge clk);
			check_seg("o_hex0", o_hex0, GLYPHS[i_sw[3:0]]);
			check_seg("o_hex1", o_hex1, GLYPHS[i_sw[7:4]]);
		end

		won = 1'b0;
		games = 0;
		while (!won && games < 8) begin
			play_binary(won);
			games++;
		end
		if (!won) begin
			errors++;
			$display("No binary-search game ended on a correct guess");
		end

		play_extremes();

		// Long press is a single guess
		set_guess(10'($urandom));
		press_enter(30, COUNT_W'(MAX_GUESSES), COUNT_W'(MAX_GUESSES - 1));
		wait_leds(1'b0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
